/* nco.f */
design/nco_pkg.sv
design/cosine.sv
design/cos_table_regs.sv
design/phase_accum.sv
design/sample_fifo.sv
design/wave_fold.sv
design/nco_top.sv
testbench/nco_assert.sv
testbench/nco_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the nco testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Done: errors found"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module nco_tb -f nco.f -o nco_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/nco_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$fail_msg" "$log"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* testbench/nco_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module nco_tb import nco_pkg::*; ();

    localparam int FIFO_DEPTH   = 4;
    localparam int REWRITE_WORD = 5;    // holds entries 20 to 23.
    localparam real PI          = 3.14159265358979;

    typedef enum int {RUN_READBACK, RUN_STREAM, RUN_RESTART, RUN_REWRITE} test_kind_t;

    typedef struct {
        string      name;
        phase_t     inc;    // phase increment for the run.
        int         count;  // samples checked.
        bit         bp;     // random out_ready when set.
        test_kind_t kind;
    } test_t;

    test_t     tests [6];
    logic      clk = 1'b0;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      out_ready;
    logic      out_valid;
    sample_t   out_sample;
    amp_t      model_tbl [64];      // reference copy of the quarter wave.
    int        seed = 32'h1b87_c574;
    int        error_count = 0;
    int        pass_count = 0;
    int        fail_count = 0;

    always #4 clk = ~clk; // 8 ns period.

    nco_top #(.PHASE_W(PHASE_W), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    // cosine over the first quadrant, sampled at half steps so the fold is symmetric.
    function automatic void build_table();
        for (int i = 0; i < 64; i++)
            model_tbl[i] = amp_t'($rtoi(255.0 * $cos((i + 0.5) * PI / 128.0) + 0.5));
    endfunction

    function automatic axi_data_t table_word(input int k);
        return {model_tbl[4*k+3], model_tbl[4*k+2], model_tbl[4*k+1], model_tbl[4*k]};
    endfunction

    function automatic void set_word(input int k, input axi_data_t word);
        for (int b = 0; b < 4; b++)
            model_tbl[4*k+b] = word[8*b +: 8]; // low byte is the lowest entry.
    endfunction

    function automatic axi_addr_t word_addr(input int k);
        return axi_addr_t'(ADDR_TABLE0 + 4 * k);
    endfunction

    // quadrant folding on the model's own table.
    function automatic sample_t expected_sample(input phase_t p);
        logic [1:0] q;
        index_t     i;
        index_t     idx;
        sample_t    mag;
        q   = p[PHASE_W-1 -: 2];
        i   = p[PHASE_W-3 -: 6];
        idx = (q == 2'd1 || q == 2'd3) ? 6'd63 - i : i; // mirrored quadrants.
        mag = sample_t'({1'b0, model_tbl[idx]});
        return (q == 2'd1 || q == 2'd2) ? -mag : mag;
    endfunction

    task automatic check_word(input string name, input axi_data_t expected,
                              input axi_data_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_sample(input string name, input sample_t expected,
                                input sample_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    // address and data together, then wait out the response.
    task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        @(negedge clk); // accepted on the edge just passed.
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) @(negedge clk);
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        @(negedge clk);
        axil_req.araddr  = addr; // kept until the data phase.
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic start_stream(input phase_t inc);
        axi_write(ADDR_PHASE_INC, axi_data_t'(inc));
        axi_write(ADDR_CTRL, 32'd1);
    endtask

    // checks count samples in order, model phase restarts at zero.
    task automatic collect(input string name, input phase_t inc, input int count,
                           input bit bp);
        phase_t phase;
        int     got;
        int     rnd;
        phase = '0;
        got   = 0;
        while (got < count) begin
            @(negedge clk);
            rnd = $random(seed);
            out_ready = bp ? rnd[0] : 1'b1;
            if (out_valid && out_ready) begin // transfer on the next rising edge.
                check_sample(name, expected_sample(phase), out_sample);
                phase = phase + inc;
                got++;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic run_readback(input string name);
        axi_data_t data;
        for (int k = 0; k < TABLE_WORDS; k++)
            axi_write(word_addr(k), table_word(k));
        for (int k = 0; k < TABLE_WORDS; k++) begin
            axi_read(word_addr(k), data);
            check_word(name, table_word(k), data);
        end
        axi_write(ADDR_PHASE_INC, 32'h0000_1234);
        axi_read(ADDR_PHASE_INC, data);
        check_word(name, 32'h0000_1234, data);
        axi_write(ADDR_CTRL, 32'd1);
        axi_read(ADDR_CTRL, data);
        check_word(name, 32'd1, data);
        axi_write(ADDR_CTRL, 32'd0);
        axi_read(ADDR_CTRL, data);
        check_word(name, 32'd0, data);
        axi_read(8'h80, data); // outside the map.
        check_word(name, 32'd0, data);
    endtask

    initial begin
        int        errors_before;
        axi_data_t saved;
        rst       = 1'b1;
        axil_req  = '0;
        out_ready = 1'b0;
        tests[0] = '{"readback", 16'd0, 0, 1'b0, RUN_READBACK};
        tests[1] = '{"slow_sweep", 16'd256, 256, 1'b0, RUN_STREAM};
        tests[2] = '{"fast_inc", 16'd4099, 300, 1'b0, RUN_STREAM};
        tests[3] = '{"back_pressure", 16'd4099, 300, 1'b1, RUN_STREAM};
        tests[4] = '{"restart", 16'd4099, 120, 1'b1, RUN_RESTART};
        tests[5] = '{"table_rewrite", 16'd256, 256, 1'b0, RUN_REWRITE};
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        foreach (tests[t]) begin
            errors_before = error_count;
            case (tests[t].kind)
                RUN_READBACK:
                    run_readback(tests[t].name);
                RUN_STREAM: begin
                    start_stream(tests[t].inc);
                    collect(tests[t].name, tests[t].inc, tests[t].count, tests[t].bp);
                    axi_write(ADDR_CTRL, 32'd0);
                end
                RUN_RESTART: begin
                    start_stream(tests[t].inc);
                    collect(tests[t].name, tests[t].inc, tests[t].count / 2, tests[t].bp);
                    repeat (3 * FIFO_DEPTH) @(negedge clk); // fifo fills with stale phases.
                    axi_write(ADDR_CTRL, 32'd0);
                    axi_write(ADDR_CTRL, 32'd1);
                    collect(tests[t].name, tests[t].inc, tests[t].count, tests[t].bp);
                    axi_write(ADDR_CTRL, 32'd0);
                end
                RUN_REWRITE: begin
                    saved = table_word(REWRITE_WORD);
                    set_word(REWRITE_WORD, 32'h0a14_1e28);
                    axi_write(word_addr(REWRITE_WORD), table_word(REWRITE_WORD));
                    start_stream(tests[t].inc);
                    collect(tests[t].name, tests[t].inc, tests[t].count, tests[t].bp);
                    axi_write(ADDR_CTRL, 32'd0);
                    set_word(REWRITE_WORD, saved); // back to the true cosine.
                    axi_write(word_addr(REWRITE_WORD), saved);
                end
                default: ;
            endcase
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %s: pass", tests[t].name);
            end else begin
                fail_count++;
                $display("test %s: fail", tests[t].name);
            end
        end

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // limit scales with the number of samples, plus room for register traffic.
    initial begin : watchdog
        int total;
        int limit;
        #1;
        total = 0;
        foreach (tests[t])
            total += tests[t].count;
        limit = total * 20 + 2000;
        repeat (limit) @(posedge clk);
        $display("error: simulation timed out after %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/nco_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module nco_assert import nco_pkg::*; (
    input wire              clk,
    input wire              rst,
    input wire axil_rsp_t   axil_rsp,
    input wire              enable,
    input wire phase_beat_t push_beat,
    input wire              full,
    input wire              out_valid,
    input wire              out_ready,
    input wire sample_t     out_sample
);

    // a stalled sample holds until it is taken.
    a_sample_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_sample))
        else $error("out_sample changed while the stream was stalled");

    // the producer pauses on a full fifo and skips no phase.
    a_pause_full: assert property (@(posedge clk) disable iff (rst)
        enable && full |=> $stable(push_beat))
        else $error("phase advanced while the fifo was full");

    // no response is pending right after reset.
    a_rsp_idle: assert property (@(posedge clk)
        rst |=> !axil_rsp.bvalid && !axil_rsp.rvalid)
        else $error("bvalid or rvalid high after reset");

endmodule

bind nco_top nco_assert u_nco_assert (
    .clk        (clk),
    .rst        (rst),
    .axil_rsp   (axil_rsp),
    .enable     (enable),
    .push_beat  (push_beat),
    .full       (full),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_sample (out_sample)
);

`default_nettype wire

/* design/nco_top.sv */
`timescale 1ns/1ns
`default_nettype none

module nco_top import nco_pkg::*; #(
    parameter int PHASE_W    = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  wire            clk,
    input  wire            rst,
    input  wire axil_req_t axil_req,
    output wire axil_rsp_t axil_rsp,
    input  wire            out_ready,
    output wire            out_valid,
    output wire sample_t   out_sample
);

    wire table_t      cos_table;  // whole quarter-wave table.
    wire phase_t      phase_inc;
    wire              enable;     // low flushes the whole data path.
    wire              push;
    wire phase_beat_t push_beat;
    wire              full;
    wire              pop_valid;
    wire              pop_ready;
    wire phase_beat_t pop_beat;

    cos_table_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .cos_table (cos_table),
        .phase_inc (phase_inc),
        .enable    (enable)
    );

    // producer.
    phase_accum #(.PHASE_W(PHASE_W)) u_accum (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .phase_inc (phase_inc),
        .full      (full),
        .push      (push),
        .push_beat (push_beat)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (~enable),
        .push      (push),
        .push_beat (push_beat),
        .pop_ready (pop_ready),
        .full      (full),
        .pop_valid (pop_valid),
        .pop_beat  (pop_beat)
    );

    // consumer, drives the sample stream.
    wave_fold #(.PHASE_W(PHASE_W)) u_fold (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .pop_valid  (pop_valid),
        .pop_beat   (pop_beat),
        .cos_table  (cos_table),
        .out_ready  (out_ready),
        .pop_ready  (pop_ready),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

endmodule

`default_nettype wire

/* design/wave_fold.sv */
`timescale 1ns/1ns
`default_nettype none

module wave_fold import nco_pkg::*; #(
    parameter int PHASE_W = nco_pkg::PHASE_W
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              enable,
    input  wire              pop_valid,
    input  wire phase_beat_t pop_beat,
    input  wire table_t      cos_table,
    input  wire              out_ready,
    output logic             pop_ready,
    output logic             out_valid,
    output sample_t          out_sample
);

    logic [1:0] quadrant;   // top two phase bits.
    index_t     index;      // next six bits.
    index_t     fold_index;
    amp_t       amp;
    logic       negate;
    sample_t    magnitude;
    sample_t    sample;

    assign quadrant = pop_beat.phase[PHASE_W-1 -: 2];
    assign index    = pop_beat.phase[PHASE_W-3 -: $bits(index_t)];

    // odd quadrants run the table backwards, ~i is 63 - i.
    assign fold_index = quadrant[0] ? ~index : index;
    assign negate     = quadrant[0] ^ quadrant[1]; // quadrants 1 and 2 are negative.

    cosine u_cosine (
        .cos_index (fold_index),
        .cos_value (amp),
        .cos_table (cos_table)
    );

    assign magnitude = sample_t'({1'b0, amp});
    assign sample    = negate ? -magnitude : magnitude;

    // take a new phase when the output stage is empty or draining.
    assign pop_ready = enable && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (rst || !enable)
            out_valid <= 1'b0; // disable drops anything pending.
        else if (pop_valid && pop_ready)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (pop_valid && pop_ready)
            out_sample <= sample; // held while out_ready is low.
    end

endmodule

`default_nettype wire

/* design/sample_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_fifo import nco_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              flush,
    input  wire              push,
    input  wire phase_beat_t push_beat,
    input  wire              pop_ready,
    output logic             full,
    output logic             pop_valid,
    output phase_beat_t      pop_beat
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

    phase_beat_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count; // beats held.
    logic             do_push;
    logic             do_pop;

    assign full      = (count == DEPTH_CNT);
    assign pop_valid = (count != '0);
    assign pop_beat  = mem[rd_ptr]; // head of the queue.

    assign do_push = push && !full;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0; // flush empties in one cycle.
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            // push and pop together leave the count alone.
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush)
            mem[wr_ptr] <= push_beat;
    end

endmodule

`default_nettype wire

/* design/phase_accum.sv */
`timescale 1ns/1ns
`default_nettype none

module phase_accum import nco_pkg::*; #(
    parameter int PHASE_W = nco_pkg::PHASE_W
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         enable,
    input  wire phase_t phase_inc,
    input  wire         full,
    output logic        push,
    output phase_beat_t push_beat
);

    logic [PHASE_W-1:0] phase_q; // running phase, wraps naturally.

    // push whenever running and the fifo has room.
    assign push = enable && !full;
    assign push_beat.phase = phase_q;

    always_ff @(posedge clk) begin
        if (rst || !enable)
            phase_q <= '0; // disable restarts from phase zero.
        else if (push)
            phase_q <= phase_q + phase_inc; // advance only on an accepted push.
    end

endmodule

`default_nettype wire

/* design/cos_table_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cos_table_regs import nco_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output table_t    cos_table,
    output phase_t    phase_inc,
    output logic      enable
);

    localparam int WORD_SEL_W = $clog2(TABLE_WORDS);

    typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_RESP} wr_state_t;
    typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_DATA} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    axi_data_t table_q [TABLE_WORDS]; // table words, four entries each.
    axi_data_t rdata_q;

    // true when the address falls inside the table window.
    function automatic logic is_table(input axi_addr_t addr);
        axi_addr_t offset;
        offset = addr - ADDR_TABLE0;
        return offset < axi_addr_t'(4 * TABLE_WORDS);
    endfunction

    function automatic logic [WORD_SEL_W-1:0] table_word(input axi_addr_t addr);
        axi_addr_t offset;
        offset = addr - ADDR_TABLE0;
        return offset[2 +: WORD_SEL_W]; // byte offset to word number.
    endfunction

    function automatic axi_data_t read_word(input axi_addr_t addr);
        axi_data_t value;
        value = '0; // unmapped addresses read zero.
        if (is_table(addr))
            value = table_q[table_word(addr)];
        else if (addr == ADDR_PHASE_INC)
            value = axi_data_t'(phase_inc);
        else if (addr == ADDR_CTRL)
            value = axi_data_t'(enable);
        return value;
    endfunction

    // write channel fsm, address and data are taken together.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= W_IDLE;
        end else begin
            case (wr_state)
                W_IDLE:
                    if (axil_req.awvalid && axil_req.wvalid)
                        wr_state <= W_ACCEPT;
                W_ACCEPT:
                    wr_state <= W_RESP; // register updates on this edge.
                W_RESP:
                    if (axil_req.bready)
                        wr_state <= W_IDLE;
                default:
                    wr_state <= W_IDLE;
            endcase
        end
    end

    // register file, written on the edge that ends the accept cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < TABLE_WORDS; k++)
                table_q[k] <= '0;
            phase_inc <= '0;
            enable    <= 1'b0;
        end else if (wr_state == W_ACCEPT) begin
            if (is_table(axil_req.awaddr))
                table_q[table_word(axil_req.awaddr)] <= axil_req.wdata;
            else if (axil_req.awaddr == ADDR_PHASE_INC)
                phase_inc <= axil_req.wdata[$bits(phase_t)-1:0];
            else if (axil_req.awaddr == ADDR_CTRL)
                enable <= axil_req.wdata[0];
            // anything else is dropped.
        end
    end

    // read channel fsm.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE:
                    if (axil_req.arvalid)
                        rd_state <= R_ACCEPT;
                R_ACCEPT:
                    rd_state <= R_DATA;
                R_DATA:
                    if (axil_req.rready)
                        rd_state <= R_IDLE;
                default:
                    rd_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == R_ACCEPT)
            rdata_q <= read_word(axil_req.araddr); // held through R_DATA.
    end

    always_comb begin
        axil_rsp.awready = (wr_state == W_ACCEPT);
        axil_rsp.wready  = (wr_state == W_ACCEPT); // one cycle, same as awready.
        axil_rsp.bvalid  = (wr_state == W_RESP);
        axil_rsp.arready = (rd_state == R_ACCEPT);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rvalid  = (rd_state == R_DATA);
    end

    // word k carries entries 4k to 4k+3, lowest entry in the low byte.
    always_comb begin
        for (int k = 0; k < TABLE_WORDS; k++)
            cos_table[$bits(axi_data_t)*k +: $bits(axi_data_t)] = table_q[k];
    end

endmodule

`default_nettype wire

/* design/cosine.sv */
`timescale 1ns/1ns
`default_nettype none

module cosine import nco_pkg::*; (
    input  wire index_t cos_index,
    output amp_t        cos_value,
    input  wire table_t cos_table
);

    localparam int ENTRIES = 1 << $bits(index_t);

    amp_t entry [ENTRIES]; // table bus split into its 64 amplitudes.

    // entry i comes from bits 8i+7 down to 8i.
    always_comb begin
        for (int i = 0; i < ENTRIES; i++)
            entry[i] = cos_table[$bits(amp_t)*i +: $bits(amp_t)];
    end

    // 64 to 1 selection, purely combinational.
    assign cos_value = entry[cos_index];

endmodule

`default_nettype wire

/* design/nco_pkg.sv */
`default_nettype none

package nco_pkg;

    // default accumulator width, nco_top passes its own copy down.
    localparam int PHASE_W = 16;
    localparam int TABLE_WORDS = 16; // four 8-bit entries per 32-bit word.

    typedef logic [PHASE_W-1:0]  phase_t;   // phase, full circle is 2**PHASE_W.
    typedef logic [5:0]          index_t;   // quarter-wave table index.
    typedef logic [7:0]          amp_t;     // unsigned amplitude from the table.
    typedef logic signed [8:0]   sample_t;  // signed output sample, -255 to 255.
    typedef logic [511:0]        table_t;   // entry i sits at [8i+7:8i].
    typedef logic [7:0]          axi_addr_t;
    typedef logic [31:0]         axi_data_t;

    // register map, byte addresses.
    localparam axi_addr_t ADDR_TABLE0    = 8'h00; // table word k at ADDR_TABLE0 + 4k.
    localparam axi_addr_t ADDR_PHASE_INC = 8'h40;
    localparam axi_addr_t ADDR_CTRL      = 8'h44; // bit 0 is the enable.

    // master side of the axi4-lite port.
    typedef struct packed {
        axi_addr_t awaddr;
        logic      awvalid;
        axi_data_t wdata;
        logic      wvalid;
        logic      bready;
        axi_addr_t araddr;
        logic      arvalid;
        logic      rready;
    } axil_req_t;

    // slave side, responses are always okay.
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        logic      arready;
        axi_data_t rdata;
        logic      rvalid;
    } axil_rsp_t;

    typedef struct packed {
        phase_t phase; // one buffered phase.
    } phase_beat_t;

endpackage

`default_nettype wire
